//--- exu_top.f
design/rv_isa_pkg.sv
design/exu_pipe_pkg.sv
design/bypass_if.sv
design/alu_if.sv
design/alu.sv
design/bypass_net.sv
design/exu_stage.sv
design/exu_top.sv
tb/exu_top_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module exu_top_tb -f exu_top.f -o sim_exu &&
./obj_dir/sim_exu | tee /dev/stderr | grep -qx "No errors" &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- tb/exu_top_tb.sv
`default_nettype none

module exu_top_tb import rv_isa_pkg::*; import exu_pipe_pkg::*; ();

    // Rough instruction count over all tests and a generous cycle budget for each
    localparam int n_instr   = 160;
    localparam int wd_limit  = n_instr * 60 * 8;

    typedef struct {
        logic [31:0] pc, imm, src1, src2, csr_rdata;
        logic [3:0]  rd, rs1, rs2;
        logic [4:0]  op;
        logic        src1_is_pc, src2_is_imm, is_jump, is_load, is_store, gpr_we;
        logic        csr_rw, csr_rs, ecall, mret;
    } instr_t;

    typedef struct packed {
        logic [31:0] pc, result, store_data, csr_wdata;
        logic [3:0]  rd, csr_sel;
        logic        gpr_we, is_load, is_store, csr_we;
    } out_t;

    logic clk, rst;
    logic in_valid, in_ready, in_src1_is_pc, in_src2_is_imm, in_is_jump, in_is_load;
    logic in_is_store, in_gpr_we, in_csr_rw, in_csr_rs, in_ecall, in_mret;
    logic [31:0] in_pc, in_imm, in_src1, in_src2, in_csr_rdata;
    logic [3:0]  in_rd, in_rs1, in_rs2;
    logic [4:0]  in_alu_op;
    logic out_valid, out_ready, out_gpr_we, out_is_load, out_is_store, out_csr_we;
    logic [31:0] out_pc, out_result, out_store_data, out_csr_wdata;
    logic [3:0]  out_rd, out_csr_sel;
    logic load_valid, redirect_valid, redirect_ack;
    logic [31:0] load_data, redirect_pc;

    // Reference copy of the forwarding history with entry 0 as the newest
    logic        m_valid [4];
    logic        m_pend  [4];
    logic [3:0]  m_rd    [4];
    logic [31:0] m_data  [4];
    logic        m_redir;
    out_t        exp_q [$];
    logic [31:0] lfsr = 32'hb793_a834;
    logic [31:0] pc_ctr = 32'h1000;
    logic        bp_mode = 1'b0;
    int          errors = 0;

    exu_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] alu_model(input logic [4:0] op, input logic [31:0] a, b);
        case (op)
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            op_sra:  return 32'($signed(a) >>> b[4:0]);
            op_slt:  return {31'b0, $signed(a) < $signed(b)};
            op_sltu: return {31'b0, a < b};
            default: return a + b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [4:0] op, input logic [31:0] c, d);
        case (op)
            op_beq:  return c == d;
            op_bne:  return c != d;
            op_blt:  return $signed(c) < $signed(d);
            op_bge:  return $signed(c) >= $signed(d);
            op_bltu: return c < d;
            op_bgeu: return c >= d;
            op_jal:  return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [3:0] onehot_select(input logic [11:0] num);
        case (num)
            csr_mtvec:   return 4'b1000;
            csr_mepc:    return 4'b0100;
            csr_mstatus: return 4'b0010;
            csr_mcause:  return 4'b0001;
            default:     return 4'b0000;
        endcase
    endfunction

    // Newest matching entry wins; x0 never matches
    task automatic lookup(input logic [3:0] rs, input logic [31:0] reg_val,
                          output logic [31:0] val, output logic pend);
        val = reg_val;
        pend = 1'b0;
        for (int i = 3; i >= 0; i--) begin
            if (m_valid[i] && m_rd[i] == rs && rs != 4'd0) begin
                val = m_data[i];
                pend = m_pend[i];
            end
        end
    endtask

    task automatic push_history(input logic [3:0] rd, input logic [31:0] d, input logic ld);
        for (int i = 3; i > 0; i--) begin
            m_valid[i] = m_valid[i-1];
            m_pend[i] = m_pend[i-1];
            m_rd[i] = m_rd[i-1];
            m_data[i] = m_data[i-1];
        end
        m_valid[0] = 1'b1;
        m_pend[0] = ld;
        m_rd[0] = rd;
        m_data[0] = d;
    endtask

    // Returned load data belongs to the oldest load still waiting
    task automatic fill_oldest_load(input logic [31:0] d);
        int oldest;
        oldest = -1;
        for (int i = 0; i < 4; i++) begin
            if (m_pend[i]) begin
                oldest = i;
            end
        end
        if (oldest >= 0) begin
            m_pend[oldest] = 1'b0;
            m_data[oldest] = d;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got, exp);
        assert (got === exp) else begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic instr_t blank();
        instr_t t;
        t = '{default: '0};
        t.op = op_add;
        return t;
    endfunction

    task automatic send(input instr_t t);
        logic [31:0] s1, s2, a, b, alu_res, pc4;
        logic        p1, p2;
        out_t        e;
        t.pc = pc_ctr;
        pc_ctr += 32'd4;
        @(posedge clk);
        in_valid <= 1'b1;
        in_pc <= t.pc;
        in_imm <= t.imm;
        in_rd <= t.rd;
        in_rs1 <= t.rs1;
        in_rs2 <= t.rs2;
        in_src1 <= t.src1;
        in_src2 <= t.src2;
        in_alu_op <= t.op;
        in_src1_is_pc <= t.src1_is_pc;
        in_src2_is_imm <= t.src2_is_imm;
        in_is_jump <= t.is_jump;
        in_is_load <= t.is_load;
        in_is_store <= t.is_store;
        in_gpr_we <= t.gpr_we;
        in_csr_rw <= t.csr_rw;
        in_csr_rs <= t.csr_rs;
        in_csr_rdata <= t.csr_rdata;
        in_ecall <= t.ecall;
        in_mret <= t.mret;
        do begin
            @(negedge clk);
            lookup(t.rs1, t.src1, s1, p1);
            lookup(t.rs2, t.src2, s2, p2);
            if (p1 || p2) begin
                assert (!in_ready) else begin
                    errors++;
                    $display("in_ready high at %0t during a load-use hazard", $time);
                end
            end
        end while (!in_ready);
        if (!m_redir) begin
            a = t.src1_is_pc ? t.pc : s1;
            b = t.src2_is_imm ? t.imm : s2;
            alu_res = alu_model(t.op, a, b);
            pc4 = t.pc + 32'd4;
            e.pc = t.pc;
            e.rd = t.rd;
            e.gpr_we = t.gpr_we;
            e.is_load = t.is_load;
            e.is_store = t.is_store;
            e.result = t.is_jump ? pc4 : alu_res;
            e.store_data = s2;
            e.csr_we = t.csr_rw || t.csr_rs;
            e.csr_sel = e.csr_we ? onehot_select(t.imm[11:0]) : 4'b0;
            e.csr_wdata = t.csr_rw ? s1 : (t.csr_rs ? (s1 | t.csr_rdata) : 32'd0);
            exp_q.push_back(e);
            if (t.gpr_we) begin
                push_history(t.rd, e.csr_we ? t.csr_rdata : e.result, t.is_load);
            end
            if (t.ecall || t.mret ||
                (t.is_jump && branch_taken(t.op, s1, s2) && alu_res != pc4)) begin
                m_redir = 1'b1;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic expect_redirect(input logic taken, input logic [31:0] target);
        instr_t t;
        @(negedge clk);
        check_value("redirect_valid", {31'b0, redirect_valid}, {31'b0, taken});
        if (taken) begin
            check_value("redirect_pc", redirect_pc, target);
            // Wrong-path instructions are dropped by the stage
            for (int i = 0; i < 2; i++) begin
                t = blank();
                t.gpr_we = 1'b1;
                t.rd = 4'd9;
                t.src1 = lfsr_bits(32);
                send(t);
            end
            @(posedge clk);
            redirect_ack <= 1'b1;
            @(posedge clk);
            redirect_ack <= 1'b0;
            m_redir = 1'b0;
            @(negedge clk);
            check_value("redirect_valid", {31'b0, redirect_valid}, 32'd0);
            // The dropped writes to x9 must not reach the forwarding history
            t = blank();
            t.rs1 = 4'd9;
            t.src1 = 32'h0000_0909;
            send(t);
        end
    endtask

    task automatic random_instr();
        instr_t t;
        t = blank();
        t.op = 5'(lfsr_bits(2));
        t.rd = 4'(lfsr_bits(3));
        t.rs1 = 4'(lfsr_bits(3));
        t.rs2 = 4'(lfsr_bits(3));
        t.src1 = lfsr_bits(32);
        t.src2 = lfsr_bits(32);
        t.imm = lfsr_bits(32);
        t.src2_is_imm = lfsr_bits(1) != 0;
        t.is_store = lfsr_bits(1) != 0;
        t.gpr_we = !t.is_store;
        send(t);
    endtask

    task automatic arith_test();
        instr_t t;
        for (int op = 0; op <= 9; op++) begin
            for (int form = 0; form < 2; form++) begin
                t = blank();
                t.op = 5'(op);
                t.src2_is_imm = form != 0;
                t.src1 = lfsr_bits(32);
                t.src2 = lfsr_bits(32);
                t.imm = lfsr_bits(32);
                send(t);
            end
        end
    endtask

    task automatic forwarding_test();
        instr_t t;
        t = blank();
        t.gpr_we = 1'b1;
        t.rd = 4'd1;
        t.src1 = 32'd100;
        t.src2_is_imm = 1'b1;
        t.imm = 32'd7;
        send(t);
        t.rd = 4'd2;
        t.rs1 = 4'd1;
        t.src1 = 32'hdead_0001;
        send(t);
        // Four more writes push x1 out of the history and the first one targets x0
        for (int i = 0; i < 4; i++) begin
            t.rd = (i == 0) ? 4'd0 : 4'(10 + i);
            t.rs1 = 4'd0;
            send(t);
        end
        t.rd = 4'd3;
        t.rs1 = 4'd1;
        t.src1 = 32'h0000_0500;
        send(t);
        for (int i = 0; i < 30; i++) begin
            random_instr();
        end
    endtask

    task automatic load_use_test();
        instr_t ld, use_i;
        logic [31:0] d;
        ld = blank();
        ld.is_load = 1'b1;
        ld.gpr_we = 1'b1;
        ld.rd = 4'd5;
        ld.src2_is_imm = 1'b1;
        ld.imm = 32'h80;
        send(ld);
        use_i = blank();
        use_i.gpr_we = 1'b1;
        use_i.rd = 4'd6;
        use_i.rs1 = 4'd5;
        use_i.src1 = 32'hbad0_bad0;
        use_i.src2_is_imm = 1'b1;
        use_i.imm = 32'd1;
        d = lfsr_bits(32);
        fork
            send(use_i);
            begin
                repeat (3) @(posedge clk);
                load_valid <= 1'b1;
                load_data <= d;
                fill_oldest_load(d);
                @(posedge clk);
                load_valid <= 1'b0;
            end
        join
    endtask

    task automatic redirect_test();
        instr_t t;
        t = blank();
        t.is_jump = 1'b1;
        t.src1_is_pc = 1'b1;
        t.src2_is_imm = 1'b1;
        t.imm = 32'h40;
        t.op = op_beq;
        send(t);
        expect_redirect(1'b1, pc_ctr + 32'h3c);
        t.op = op_bne;
        send(t);
        expect_redirect(1'b0, 32'd0);
        t.op = op_jal;
        t.gpr_we = 1'b1;
        t.rd = 4'd1;
        send(t);
        expect_redirect(1'b1, pc_ctr + 32'h3c);
        t.imm = 32'd4;
        send(t);
        expect_redirect(1'b0, 32'd0);
        t = blank();
        t.ecall = 1'b1;
        t.csr_rdata = 32'h0000_0200;
        send(t);
        expect_redirect(1'b1, 32'h0000_0200);
        t.ecall = 1'b0;
        t.mret = 1'b1;
        t.csr_rdata = 32'h0000_1230;
        send(t);
        expect_redirect(1'b1, 32'h0000_1230);
    endtask

    task automatic csr_test();
        instr_t t, rd_back;
        logic [11:0] nums [5];
        nums = '{csr_mstatus, csr_mtvec, csr_mepc, csr_mcause, 12'h7c0};
        for (int n = 0; n < 5; n++) begin
            for (int k = 0; k < 2; k++) begin
                t = blank();
                t.csr_rw = k == 0;
                t.csr_rs = k != 0;
                t.imm = {20'(lfsr_bits(20)), nums[n]};
                t.src1 = lfsr_bits(32);
                t.csr_rdata = lfsr_bits(32);
                t.gpr_we = 1'b1;
                t.rd = 4'd3;
                send(t);
                rd_back = blank();
                rd_back.rs1 = 4'd3;
                rd_back.src2_is_imm = 1'b1;
                send(rd_back);
            end
        end
    endtask

    initial begin
        out_t cur, snap;
        logic stalled;
        stalled = 1'b0;
        forever begin
            @(negedge clk);
            cur = '{out_pc, out_result, out_store_data, out_csr_wdata, out_rd, out_csr_sel,
                    out_gpr_we, out_is_load, out_is_store, out_csr_we};
            if (out_valid && stalled) begin
                assert (cur == snap) else begin
                    errors++;
                    $display("Output payload changed under back-pressure at %0t", $time);
                end
            end
            stalled = out_valid && !out_ready;
            snap = cur;
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Unexpected output at %0t with pc %h", $time, out_pc);
                end else begin
                    snap = exp_q.pop_front();
                    check_value("out_pc", out_pc, snap.pc);
                    check_value("out_result", out_result, snap.result);
                    check_value("out_store_data", out_store_data, snap.store_data);
                    check_value("out_csr_wdata", out_csr_wdata, snap.csr_wdata);
                    check_value("out_rd", {28'b0, out_rd}, {28'b0, snap.rd});
                    check_value("out_csr_sel", {28'b0, out_csr_sel}, {28'b0, snap.csr_sel});
                    check_value("out_flags", {28'b0, out_gpr_we, out_is_load, out_is_store,
                                out_csr_we}, {28'b0, snap.gpr_we, snap.is_load,
                                snap.is_store, snap.csr_we});
                end
            end
        end
    end

    always @(posedge clk) begin
        out_ready <= bp_mode ? (lfsr_bits(2) != 0) : 1'b1;
    end

    initial begin
        #wd_limit;
        $display("Watchdog expired at %0t before the tests finished", $time);
        $display("Errors found");
        $finish;
    end

    initial begin
        {in_valid, in_src1_is_pc, in_src2_is_imm, in_is_jump, in_is_load} <= '0;
        {in_is_store, in_gpr_we, in_csr_rw, in_csr_rs, in_ecall, in_mret} <= '0;
        {in_pc, in_imm, in_src1, in_src2, in_csr_rdata} <= '0;
        {in_rd, in_rs1, in_rs2, in_alu_op} <= '0;
        {load_valid, load_data, redirect_ack} <= '0;
        out_ready <= 1'b1;
        m_valid = '{default: 1'b0};
        m_pend = '{default: 1'b0};
        m_rd = '{default: 4'd0};
        m_data = '{default: 32'd0};
        m_redir = 1'b0;
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        arith_test();
        forwarding_test();
        load_use_test();
        redirect_test();
        csr_test();
        bp_mode = 1'b1;
        for (int i = 0; i < 30; i++) begin
            random_instr();
        end
        bp_mode = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        $display("Tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/exu_top.sv
`default_nettype none

module exu_top
    import rv_isa_pkg::*;
    import exu_pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic [xlen-1:0]      in_pc,
    input  logic [xlen-1:0]      in_imm,
    input  logic [reg_idx_w-1:0] in_rd,
    input  logic [reg_idx_w-1:0] in_rs1,
    input  logic [reg_idx_w-1:0] in_rs2,
    input  logic [xlen-1:0]      in_src1,
    input  logic [xlen-1:0]      in_src2,
    input  logic [alu_op_w-1:0]  in_alu_op,
    input  logic                 in_src1_is_pc,
    input  logic                 in_src2_is_imm,
    input  logic                 in_is_jump,
    input  logic                 in_is_load,
    input  logic                 in_is_store,
    input  logic                 in_gpr_we,
    input  logic                 in_csr_rw,
    input  logic                 in_csr_rs,
    input  logic [xlen-1:0]      in_csr_rdata,
    input  logic                 in_ecall,
    input  logic                 in_mret,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic [xlen-1:0]      out_pc,
    output logic [reg_idx_w-1:0] out_rd,
    output logic                 out_gpr_we,
    output logic                 out_is_load,
    output logic                 out_is_store,
    output logic [xlen-1:0]      out_result,
    output logic [xlen-1:0]      out_store_data,
    output logic                 out_csr_we,
    output logic [csr_sel_w-1:0] out_csr_sel,
    output logic [xlen-1:0]      out_csr_wdata,
    input  logic                 load_valid,
    input  logic [xlen-1:0]      load_data,
    output logic                 redirect_valid,
    output logic [xlen-1:0]      redirect_pc,
    input  logic                 redirect_ack
);

    bypass_if byp_bus ();
    alu_if    alu_bus ();

    exu_stage stage_i (
        .byp (byp_bus),
        .alu (alu_bus),
        .*
    );

    bypass_net bypass_i (
        .clk (clk),
        .rst (rst),
        .byp (byp_bus)
    );

    alu alu_i (
        .alu (alu_bus)
    );

endmodule

`default_nettype wire

//--- design/exu_stage.sv
`default_nettype none

module exu_stage
    import rv_isa_pkg::*;
    import exu_pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic [xlen-1:0]      in_pc,
    input  logic [xlen-1:0]      in_imm,
    input  logic [reg_idx_w-1:0] in_rd,
    input  logic [reg_idx_w-1:0] in_rs1,
    input  logic [reg_idx_w-1:0] in_rs2,
    input  logic [xlen-1:0]      in_src1,
    input  logic [xlen-1:0]      in_src2,
    input  logic [alu_op_w-1:0]  in_alu_op,
    input  logic                 in_src1_is_pc,
    input  logic                 in_src2_is_imm,
    input  logic                 in_is_jump,
    input  logic                 in_is_load,
    input  logic                 in_is_store,
    input  logic                 in_gpr_we,
    input  logic                 in_csr_rw,
    input  logic                 in_csr_rs,
    input  logic [xlen-1:0]      in_csr_rdata,
    input  logic                 in_ecall,
    input  logic                 in_mret,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic [xlen-1:0]      out_pc,
    output logic [reg_idx_w-1:0] out_rd,
    output logic                 out_gpr_we,
    output logic                 out_is_load,
    output logic                 out_is_store,
    output logic [xlen-1:0]      out_result,
    output logic [xlen-1:0]      out_store_data,
    output logic                 out_csr_we,
    output logic [csr_sel_w-1:0] out_csr_sel,
    output logic [xlen-1:0]      out_csr_wdata,
    input  logic                 load_valid,
    input  logic [xlen-1:0]      load_data,
    output logic                 redirect_valid,
    output logic [xlen-1:0]      redirect_pc,
    input  logic                 redirect_ack,
    bypass_if.stage              byp,
    alu_if.stage                 alu
);

    logic [xlen-1:0]      src1;
    logic [xlen-1:0]      src2;
    logic [xlen-1:0]      pc_plus4;
    logic [xlen-1:0]      result;
    logic [xlen-1:0]      csr_wdata;
    logic [csr_sel_w-1:0] csr_sel;
    logic                 is_csr;
    logic                 trap;
    logic                 take_jump;
    logic                 keep;
    imm_csr_u             imm_view;

    assign imm_view = in_imm;
    assign in_ready = (!out_valid || out_ready) && !byp.hazard;
    // Wrong-path instructions are accepted and dropped while a redirect waits
    assign keep     = in_valid && in_ready && !redirect_valid;

    assign byp.rs1        = in_rs1;
    assign byp.rs2        = in_rs2;
    assign byp.src1_reg   = in_src1;
    assign byp.src2_reg   = in_src2;
    assign byp.load_valid = load_valid;
    assign byp.load_data  = load_data;
    assign src1 = byp.src1_fwd;
    assign src2 = byp.src2_fwd;

    assign alu.op = in_alu_op;
    assign alu.a  = in_src1_is_pc ? in_pc : src1;
    assign alu.b  = in_src2_is_imm ? imm_view.imm : src2;
    assign alu.c  = src1;
    assign alu.d  = src2;

    assign pc_plus4  = in_pc + xlen'(4);
    assign result    = in_is_jump ? pc_plus4 : alu.result;
    assign is_csr    = in_csr_rw || in_csr_rs;
    assign trap      = in_ecall || in_mret;
    assign take_jump = in_is_jump && alu.cond && (alu.result != pc_plus4);

    assign byp.push         = keep && in_gpr_we;
    assign byp.push_rd      = in_rd;
    assign byp.push_data    = is_csr ? in_csr_rdata : result;
    assign byp.push_is_load = in_is_load;

    assign csr_wdata = ({xlen{in_csr_rw}} & src1)
                     | ({xlen{in_csr_rs}} & (src1 | in_csr_rdata));

    always_comb begin
        case (imm_view.csr_view.num)
            csr_mtvec:   csr_sel = 4'b1000;
            csr_mepc:    csr_sel = 4'b0100;
            csr_mstatus: csr_sel = 4'b0010;
            csr_mcause:  csr_sel = 4'b0001;
            default:     csr_sel = '0;
        endcase
        if (!is_csr) begin
            csr_sel = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            if (!out_valid || out_ready) begin
                out_valid <= keep;
            end
            if (keep && (trap || take_jump)) begin
                redirect_valid <= 1'b1;
            end else if (redirect_ack) begin
                redirect_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (keep) begin
            out_pc         <= in_pc;
            out_rd         <= in_rd;
            out_gpr_we     <= in_gpr_we;
            out_is_load    <= in_is_load;
            out_is_store   <= in_is_store;
            out_result     <= result;
            out_store_data <= src2;
            out_csr_we     <= is_csr;
            out_csr_sel    <= csr_sel;
            out_csr_wdata  <= csr_wdata;
        end
        if (keep && (trap || take_jump)) begin
            redirect_pc <= trap ? in_csr_rdata : alu.result;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable({out_pc, out_rd, out_gpr_we,
            out_is_load, out_is_store, out_result, out_store_data, out_csr_we,
            out_csr_sel, out_csr_wdata}))
        else $error("output payload changed while stalled");

    assert property (@(posedge clk) disable iff (rst)
        redirect_valid && !redirect_ack |=> redirect_valid && $stable(redirect_pc))
        else $error("redirect dropped before acknowledge");

endmodule

`default_nettype wire

//--- design/bypass_net.sv
`default_nettype none

module bypass_net
    import rv_isa_pkg::*;
    import exu_pipe_pkg::*;
(
    input logic   clk,
    input logic   rst,
    bypass_if.net byp
);

    // Entry 0 is the newest write
    logic [bypass_depth-1:0] ent_valid;
    logic [bypass_depth-1:0] ent_pending;
    logic [reg_idx_w-1:0]    ent_rd   [bypass_depth];
    logic [xlen-1:0]         ent_data [bypass_depth];

    logic [bypass_depth-1:0] fill_sel;
    logic [bypass_depth-1:0] pend_now;
    logic [xlen-1:0]         data_now [bypass_depth];
    logic                    src1_wait;
    logic                    src2_wait;

    // Loads return in order, so a fill goes to the oldest pending entry
    always_comb begin
        fill_sel = '0;
        for (int i = 0; i < bypass_depth; i++) begin
            if (ent_pending[i]) begin
                fill_sel    = '0;
                fill_sel[i] = byp.load_valid;
            end
        end
        pend_now = ent_pending & ~fill_sel;
        for (int i = 0; i < bypass_depth; i++) begin
            data_now[i] = fill_sel[i] ? byp.load_data : ent_data[i];
        end
    end

    // Returns {wait, value}; later iterations are newer and win
    function automatic logic [xlen:0] lookup(input logic [reg_idx_w-1:0] rs,
                                             input logic [xlen-1:0]      reg_val);
        logic [xlen:0] res;
        res = {1'b0, reg_val};
        for (int i = bypass_depth - 1; i >= 0; i--) begin
            if (ent_valid[i] && ent_rd[i] == rs && rs != '0) begin
                res = {pend_now[i], data_now[i]};
            end
        end
        return res;
    endfunction

    assign {src1_wait, byp.src1_fwd} = lookup(byp.rs1, byp.src1_reg);
    assign {src2_wait, byp.src2_fwd} = lookup(byp.rs2, byp.src2_reg);
    assign byp.hazard = src1_wait || src2_wait;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid   <= '0;
            ent_pending <= '0;
        end else if (byp.push) begin
            ent_valid   <= {ent_valid[bypass_depth-2:0], 1'b1};
            ent_pending <= {pend_now[bypass_depth-2:0], byp.push_is_load};
        end else begin
            ent_pending <= pend_now;
        end
    end

    always_ff @(posedge clk) begin
        if (byp.push) begin
            for (int i = bypass_depth - 1; i > 0; i--) begin
                ent_rd[i]   <= ent_rd[i-1];
                ent_data[i] <= data_now[i-1];
            end
            ent_rd[0]   <= byp.push_rd;
            ent_data[0] <= byp.push_data;
        end else begin
            for (int i = 0; i < bypass_depth; i++) begin
                ent_data[i] <= data_now[i];
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) byp.load_valid |-> |ent_pending)
        else $error("load data returned with no pending load in the history");

endmodule

`default_nettype wire

//--- design/alu.sv
`default_nettype none

module alu import rv_isa_pkg::*; (
    alu_if.alu alu
);

    logic [xlen-1:0] sum;

    assign sum = alu.a + alu.b;

    always_comb begin
        case (alu.op)
            op_add:  alu.result = sum;
            op_sub:  alu.result = alu.a - alu.b;
            op_and:  alu.result = alu.a & alu.b;
            op_or:   alu.result = alu.a | alu.b;
            op_xor:  alu.result = alu.a ^ alu.b;
            op_sll:  alu.result = alu.a << alu.b[4:0];
            op_srl:  alu.result = alu.a >> alu.b[4:0];
            op_sra:  alu.result = $signed(alu.a) >>> alu.b[4:0];
            op_slt:  alu.result = {{(xlen-1){1'b0}}, $signed(alu.a) < $signed(alu.b)};
            op_sltu: alu.result = {{(xlen-1){1'b0}}, alu.a < alu.b};
            // Branches and jal produce the jump target
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu, op_jal:
                alu.result = sum;
            default: alu.result = '0;
        endcase
    end

    always_comb begin
        case (alu.op)
            op_beq:  alu.cond = alu.c == alu.d;
            op_bne:  alu.cond = alu.c != alu.d;
            op_blt:  alu.cond = $signed(alu.c) < $signed(alu.d);
            op_bge:  alu.cond = $signed(alu.c) >= $signed(alu.d);
            op_bltu: alu.cond = alu.c < alu.d;
            op_bgeu: alu.cond = alu.c >= alu.d;
            op_jal:  alu.cond = 1'b1;
            default: alu.cond = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/alu_if.sv
`default_nettype none

interface alu_if import rv_isa_pkg::*; ();

    logic [alu_op_w-1:0] op;
    logic [xlen-1:0]     a;
    logic [xlen-1:0]     b;
    // Forwarded register values for branch compares
    logic [xlen-1:0]     c;
    logic [xlen-1:0]     d;
    logic [xlen-1:0]     result;
    logic                cond;

    modport stage (output op, a, b, c, d, input result, cond);

    modport alu (input op, a, b, c, d, output result, cond);

endinterface

`default_nettype wire

//--- design/bypass_if.sv
`default_nettype none

interface bypass_if import rv_isa_pkg::*; ();

    logic [reg_idx_w-1:0] rs1;
    logic [reg_idx_w-1:0] rs2;
    logic [xlen-1:0]      src1_reg;
    logic [xlen-1:0]      src2_reg;
    logic                 push;
    logic [reg_idx_w-1:0] push_rd;
    logic [xlen-1:0]      push_data;
    logic                 push_is_load;
    logic                 load_valid;
    logic [xlen-1:0]      load_data;
    logic [xlen-1:0]      src1_fwd;
    logic [xlen-1:0]      src2_fwd;
    logic                 hazard;

    modport stage (
        output rs1, rs2, src1_reg, src2_reg,
        output push, push_rd, push_data, push_is_load,
        output load_valid, load_data,
        input  src1_fwd, src2_fwd, hazard
    );

    modport net (
        input  rs1, rs2, src1_reg, src2_reg,
        input  push, push_rd, push_data, push_is_load,
        input  load_valid, load_data,
        output src1_fwd, src2_fwd, hazard
    );

endinterface

`default_nettype wire

//--- design/exu_pipe_pkg.sv
`default_nettype none

package exu_pipe_pkg;

    // Number of register writes the forwarding history remembers
    localparam int bypass_depth = 4;

    // One-hot order from the msb is mtvec, mepc, mstatus, mcause
    localparam int csr_sel_w = 4;

    // CSR instructions carry the CSR number in the low bits of the immediate
    typedef union packed {
        logic [31:0] imm;
        struct packed {
            logic [19:0] unused;
            logic [11:0] num;
        } csr_view;
    } imm_csr_u;

endpackage

`default_nettype wire

//--- design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // RV32E has 16 architectural registers
    localparam int reg_idx_w = 4;
    localparam int xlen      = 32;
    localparam int alu_op_w  = 5;

    localparam logic [alu_op_w-1:0] op_add  = 5'd0;
    localparam logic [alu_op_w-1:0] op_sub  = 5'd1;
    localparam logic [alu_op_w-1:0] op_and  = 5'd2;
    localparam logic [alu_op_w-1:0] op_or   = 5'd3;
    localparam logic [alu_op_w-1:0] op_xor  = 5'd4;
    localparam logic [alu_op_w-1:0] op_sll  = 5'd5;
    localparam logic [alu_op_w-1:0] op_srl  = 5'd6;
    localparam logic [alu_op_w-1:0] op_sra  = 5'd7;
    localparam logic [alu_op_w-1:0] op_slt  = 5'd8;
    localparam logic [alu_op_w-1:0] op_sltu = 5'd9;

    // Branch codes compare c with d and add a and b for the target
    localparam logic [alu_op_w-1:0] op_beq  = 5'd10;
    localparam logic [alu_op_w-1:0] op_bne  = 5'd11;
    localparam logic [alu_op_w-1:0] op_blt  = 5'd12;
    localparam logic [alu_op_w-1:0] op_bge  = 5'd13;
    localparam logic [alu_op_w-1:0] op_bltu = 5'd14;
    localparam logic [alu_op_w-1:0] op_bgeu = 5'd15;
    localparam logic [alu_op_w-1:0] op_jal  = 5'd16;

    localparam logic [11:0] csr_mstatus = 12'h300;
    localparam logic [11:0] csr_mtvec   = 12'h305;
    localparam logic [11:0] csr_mepc    = 12'h341;
    localparam logic [11:0] csr_mcause  = 12'h342;

endpackage

`default_nettype wire
